/* compile.f */
+incdir+logic
logic/cpu_ctrl_pkg.sv
logic/instr_decoder.sv
logic/exec_unit.sv
logic/ctrl_pipe.sv
logic/cpu_ctrl_top.sv
testbench/tb_cpu_ctrl_top.sv

/* logic/cpu_ctrl_macros.svh */
`ifndef CPU_CTRL_MACROS_SVH
`define CPU_CTRL_MACROS_SVH

// Datapath width (8 and 32 work as well)
`define CPU_DATA_W    16

// Instruction opcode field
`define CPU_OPCODE_W  5

// Control word field widths
`define CPU_ALU_OP_W  4
`define CPU_JUMP_W    2

// Shift amount taken from the low bits of imm
`define CPU_SHAMT_W   4

// Flag register layout
`define CPU_FLAG_W    3
`define CPU_FLAG_Z    0
`define CPU_FLAG_N    1
`define CPU_FLAG_C    2

`endif

/* logic/cpu_ctrl_pkg.sv */
`include "cpu_ctrl_macros.svh"

package cpu_ctrl_pkg;

    typedef logic [`CPU_DATA_W-1:0] data_t;
    typedef logic [`CPU_FLAG_W-1:0] flags_t;   // Z, N, C

    typedef enum logic [`CPU_OPCODE_W-1:0] {
        OP_NOP   = 5'd0,
        OP_SETC  = 5'd1,
        OP_CLRC  = 5'd2,
        OP_NOT   = 5'd3,
        OP_INC   = 5'd4,
        OP_DEC   = 5'd5,
        OP_IN    = 5'd6,
        OP_OUT   = 5'd7,
        OP_PUSH  = 5'd8,
        OP_POP   = 5'd9,
        OP_LOAD  = 5'd10,
        OP_STORE = 5'd12,
        OP_LDM   = 5'd13,
        OP_JZ    = 5'd16,
        OP_JN    = 5'd17,
        OP_JC    = 5'd18,
        OP_MOV   = 5'd24,
        OP_ADD   = 5'd25,
        OP_SUB   = 5'd26,
        OP_AND   = 5'd28,
        OP_OR    = 5'd29,
        OP_SHL   = 5'd30,
        OP_SHR   = 5'd31
    } opcode_t;

    typedef enum logic [`CPU_ALU_OP_W-1:0] {
        ALU_NONE = 4'd0,
        ALU_NOT  = 4'd1,
        ALU_INC  = 4'd2,
        ALU_DEC  = 4'd3,
        ALU_MOV  = 4'd4,
        ALU_ADD  = 4'd5,
        ALU_SUB  = 4'd6,
        ALU_AND  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_SHL  = 4'd9,
        ALU_SHR  = 4'd10,
        ALU_SETC = 4'd11,
        ALU_CLRC = 4'd12,
        ALU_PASS = 4'd13
    } alu_op_t;

    typedef enum logic [`CPU_JUMP_W-1:0] {
        JMP_NONE  = 2'd0,
        JMP_ZERO  = 2'd1,
        JMP_NEG   = 2'd2,
        JMP_CARRY = 2'd3
    } jump_type_t;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       mem_read;
        logic       mem_write;
        logic       push;
        logic       pop;
        logic       in_port;
        logic       out_port;
        logic       immediate;
        logic       one_operand;   // NOT, INC, DEC
        logic       wb;
        jump_type_t jump_type;
    } ctrl_word_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        data_t      operand_a;
        data_t      operand_b;
        data_t      imm;
    } ex_stage_t;

    typedef struct packed {
        logic  mem_read;
        logic  mem_write;
        logic  push;
        logic  pop;
        logic  out_port;
        logic  wb;
        data_t result;       // Address or write-back value
        data_t store_data;
    } mem_stage_t;

    typedef struct packed {
        logic  wb;
        data_t wb_data;
    } wb_stage_t;

endpackage

/* logic/cpu_ctrl_top.sv */
module cpu_ctrl_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_ctrl_pkg::opcode_t    opcode,
    input  cpu_ctrl_pkg::data_t      operand_a,
    input  cpu_ctrl_pkg::data_t      operand_b,
    input  cpu_ctrl_pkg::data_t      imm,
    input  cpu_ctrl_pkg::data_t      mem_rdata,
    output cpu_ctrl_pkg::mem_stage_t mem_stage,
    output cpu_ctrl_pkg::wb_stage_t  wb_stage,
    output cpu_ctrl_pkg::flags_t     flags,
    output logic                     jump_taken
);
    import cpu_ctrl_pkg::*;

    ex_stage_t  ex_stage;
    ctrl_word_t ex_ctrl;
    data_t      alu_result;

    instr_decoder u_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .opcode     (opcode),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .imm        (imm),
        .jump_taken (jump_taken),
        .ex_stage   (ex_stage)
    );

    exec_unit u_exec (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_stage   (ex_stage),
        .alu_result (alu_result),
        .ex_ctrl    (ex_ctrl),
        .flags      (flags),
        .jump_taken (jump_taken)
    );

    ctrl_pipe u_pipe (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_ctrl    (ex_ctrl),
        .alu_result (alu_result),
        .store_data (ex_stage.operand_b),   // Register value for STORE
        .mem_rdata  (mem_rdata),
        .mem_stage  (mem_stage),
        .wb_stage   (wb_stage)
    );

endmodule

/* logic/ctrl_pipe.sv */
module ctrl_pipe (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_ctrl_pkg::ctrl_word_t ex_ctrl,
    input  cpu_ctrl_pkg::data_t      alu_result,
    input  cpu_ctrl_pkg::data_t      store_data,
    input  cpu_ctrl_pkg::data_t      mem_rdata,
    output cpu_ctrl_pkg::mem_stage_t mem_stage,
    output cpu_ctrl_pkg::wb_stage_t  wb_stage
);
    import cpu_ctrl_pkg::*;

    ctrl_word_t mem_ctrl_q;
    data_t      mem_result_q;
    data_t      mem_store_q;
    logic       mem_load;
    logic       wb_q;
    data_t      wb_data_q;

    // Memory stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_ctrl_q <= '0;
        end else begin
            mem_ctrl_q <= ex_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        mem_result_q <= alu_result;
        mem_store_q  <= store_data;
    end

    assign mem_stage = '{
        mem_read:   mem_ctrl_q.mem_read,
        mem_write:  mem_ctrl_q.mem_write,
        push:       mem_ctrl_q.push,
        pop:        mem_ctrl_q.pop,
        out_port:   mem_ctrl_q.out_port,
        wb:         mem_ctrl_q.wb,
        result:     mem_result_q,
        store_data: mem_store_q
    };

    // LDM carries its value from imm through the ALU
    assign mem_load = mem_ctrl_q.mem_read && !mem_ctrl_q.immediate;

    // Writeback stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_q <= 1'b0;
        end else begin
            wb_q <= mem_ctrl_q.wb;
        end
    end

    always_ff @(posedge clk) begin
        wb_data_q <= mem_load ? mem_rdata : mem_result_q;   // Read data sampled here
    end

    assign wb_stage = '{
        wb:      wb_q,
        wb_data: wb_data_q
    };

endmodule

/* logic/exec_unit.sv */
`include "cpu_ctrl_macros.svh"

module exec_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_ctrl_pkg::ex_stage_t  ex_stage,
    output cpu_ctrl_pkg::data_t      alu_result,
    output cpu_ctrl_pkg::ctrl_word_t ex_ctrl,
    output cpu_ctrl_pkg::flags_t     flags,
    output logic                     jump_taken
);
    import cpu_ctrl_pkg::*;

    data_t                   op_a;
    data_t                   op_b;
    data_t                   imm;
    data_t                   addend;
    logic [`CPU_SHAMT_W-1:0] shamt;
    logic [`CPU_DATA_W:0]    sum_ext;    // Top bit is carry out
    logic [`CPU_DATA_W:0]    diff_ext;   // Top bit is borrow
    logic                    upd_zn;
    logic                    upd_c;
    logic                    carry_next;
    flags_t                  flags_next;

    assign op_a  = ex_stage.operand_a;
    assign op_b  = ex_stage.operand_b;
    assign imm   = ex_stage.imm;
    assign shamt = imm[`CPU_SHAMT_W-1:0];

    // One adder serves ADD/SUB and INC/DEC
    assign addend   = ex_stage.ctrl.one_operand ? data_t'(1) : op_b;
    assign sum_ext  = {1'b0, op_a} + {1'b0, addend};
    assign diff_ext = {1'b0, op_a} - {1'b0, addend};

    always_comb begin
        case (ex_stage.ctrl.alu_op)
            ALU_NOT:  alu_result = ~op_a;
            ALU_INC,
            ALU_ADD:  alu_result = sum_ext[`CPU_DATA_W-1:0];
            ALU_DEC,
            ALU_SUB:  alu_result = diff_ext[`CPU_DATA_W-1:0];
            ALU_MOV:  alu_result = op_b;                 // Source register
            ALU_AND:  alu_result = op_a & op_b;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_SHL:  alu_result = op_a << shamt;
            ALU_SHR:  alu_result = op_a >> shamt;
            ALU_PASS: alu_result = ex_stage.ctrl.immediate ? imm : op_a;
            default:  alu_result = '0;
        endcase
    end

    // Which flags this operation touches
    always_comb begin
        upd_zn     = 1'b0;
        upd_c      = 1'b0;
        carry_next = flags[`CPU_FLAG_C];
        case (ex_stage.ctrl.alu_op)
            ALU_ADD, ALU_INC: begin
                upd_zn     = 1'b1;
                upd_c      = 1'b1;
                carry_next = sum_ext[`CPU_DATA_W];
            end
            ALU_SUB, ALU_DEC: begin
                upd_zn     = 1'b1;
                upd_c      = 1'b1;
                carry_next = diff_ext[`CPU_DATA_W];
            end
            ALU_NOT, ALU_AND, ALU_OR, ALU_SHL, ALU_SHR: begin
                upd_zn = 1'b1;
            end
            ALU_SETC: begin
                upd_c      = 1'b1;
                carry_next = 1'b1;
            end
            ALU_CLRC: begin
                upd_c      = 1'b1;
                carry_next = 1'b0;
            end
            default: ;                                   // MOV, PASS, NONE keep flags
        endcase
    end

    always_comb begin
        flags_next = flags;
        if (upd_zn) begin
            flags_next[`CPU_FLAG_Z] = (alu_result == '0);
            flags_next[`CPU_FLAG_N] = alu_result[`CPU_DATA_W-1];
        end
        if (upd_c) begin
            flags_next[`CPU_FLAG_C] = carry_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else begin
            flags <= flags_next;
        end
    end

    // Compared against flags of older instructions only
    always_comb begin
        case (ex_stage.ctrl.jump_type)
            JMP_ZERO:  jump_taken = flags[`CPU_FLAG_Z];
            JMP_NEG:   jump_taken = flags[`CPU_FLAG_N];
            JMP_CARRY: jump_taken = flags[`CPU_FLAG_C];
            default:   jump_taken = 1'b0;
        endcase
    end

    always_comb begin
        ex_ctrl           = ex_stage.ctrl;
        ex_ctrl.jump_type = JMP_NONE;                    // Jump consumed here
    end

endmodule

/* logic/instr_decoder.sv */
module instr_decoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cpu_ctrl_pkg::opcode_t   opcode,
    input  cpu_ctrl_pkg::data_t     operand_a,
    input  cpu_ctrl_pkg::data_t     operand_b,
    input  cpu_ctrl_pkg::data_t     imm,
    input  logic                    jump_taken,
    output cpu_ctrl_pkg::ex_stage_t ex_stage
);
    import cpu_ctrl_pkg::*;

    ctrl_word_t dec;
    ctrl_word_t ctrl_q;
    data_t      operand_a_q;
    data_t      operand_b_q;
    data_t      imm_q;

    always_comb begin
        dec = '0;
        case (opcode)
            OP_SETC:  dec.alu_op = ALU_SETC;
            OP_CLRC:  dec.alu_op = ALU_CLRC;
            OP_NOT: begin
                dec.alu_op      = ALU_NOT;
                dec.one_operand = 1'b1;
            end
            OP_INC: begin
                dec.alu_op      = ALU_INC;
                dec.one_operand = 1'b1;
            end
            OP_DEC: begin
                dec.alu_op      = ALU_DEC;
                dec.one_operand = 1'b1;
            end
            OP_IN:    dec.in_port  = 1'b1;
            OP_OUT:   dec.out_port = 1'b1;
            OP_PUSH:  dec.push     = 1'b1;
            OP_POP:   dec.pop      = 1'b1;
            OP_LOAD: begin
                dec.mem_read = 1'b1;
                dec.alu_op   = ALU_PASS;      // Address from operand_a
            end
            OP_STORE: begin
                dec.mem_write = 1'b1;
                dec.alu_op    = ALU_PASS;
            end
            OP_LDM: begin
                dec.mem_read  = 1'b1;
                dec.immediate = 1'b1;
                dec.alu_op    = ALU_PASS;     // Result is imm
            end
            OP_JZ:    dec.jump_type = JMP_ZERO;
            OP_JN:    dec.jump_type = JMP_NEG;
            OP_JC:    dec.jump_type = JMP_CARRY;
            OP_MOV:   dec.alu_op = ALU_MOV;
            OP_ADD:   dec.alu_op = ALU_ADD;
            OP_SUB:   dec.alu_op = ALU_SUB;
            OP_AND:   dec.alu_op = ALU_AND;
            OP_OR:    dec.alu_op = ALU_OR;
            OP_SHL: begin
                dec.alu_op    = ALU_SHL;
                dec.immediate = 1'b1;        // Shift amount in imm
            end
            OP_SHR: begin
                dec.alu_op    = ALU_SHR;
                dec.immediate = 1'b1;
            end
            default: ;                        // Unused codes act as NOP
        endcase

        // Anything producing a value writes back, except a store
        dec.wb = ((dec.alu_op != ALU_NONE) && (dec.alu_op != ALU_SETC) &&
                  (dec.alu_op != ALU_CLRC)) || dec.mem_read;
        if (dec.mem_write) begin
            dec.wb = 1'b0;
        end
    end

    // A taken jump turns the younger instruction into a bubble
    always_ff @(posedge clk) begin
        if (!rst_n || jump_taken) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= dec;
        end
    end

    always_ff @(posedge clk) begin
        operand_a_q <= operand_a;
        operand_b_q <= operand_b;
        imm_q       <= imm;
    end

    assign ex_stage = '{
        ctrl:      ctrl_q,
        operand_a: operand_a_q,
        operand_b: operand_b_q,
        imm:       imm_q
    };

endmodule

/* testbench/tb_cpu_ctrl_top.sv */
`include "cpu_ctrl_macros.svh"

module tb_cpu_ctrl_top;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_ctrl_pkg::*;

    localparam int N_ALU = 300;                       // Random ALU instructions
    // Three cycles per instruction and four per jump pair
    localparam int TEST_CYCLES = 4 + 3 * N_ALU + 3 * 7 + 3 * 4 + 3 * 3 + 4 * 6;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

    logic       clk = 1'b0;
    logic       rst_n;
    opcode_t    opcode;
    data_t      operand_a;
    data_t      operand_b;
    data_t      imm;
    data_t      mem_rdata;
    mem_stage_t mem_stage;
    wb_stage_t  wb_stage;
    flags_t     flags;
    logic       jump_taken;

    flags_t     model_flags_q;                        // Flags predicted by the model
    string      cur_test;
    int         errors;
    int         checks;
    int         tests;
    int         err_mark;
    opcode_t    alu_ops [10] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOT,
                                 OP_INC, OP_DEC, OP_MOV, OP_SHL, OP_SHR};

    cpu_ctrl_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .opcode     (opcode),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .imm        (imm),
        .mem_rdata  (mem_rdata),
        .mem_stage  (mem_stage),
        .wb_stage   (wb_stage),
        .flags      (flags),
        .jump_taken (jump_taken)
    );

    always #20 clk = ~clk;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    function automatic data_t model_result(opcode_t op, data_t a, data_t b, data_t im);
        case (op)
            OP_NOT:            return ~a;
            OP_INC:            return a + 1'b1;
            OP_DEC:            return a - 1'b1;
            OP_MOV:            return b;
            OP_ADD:            return a + b;
            OP_SUB:            return a - b;
            OP_AND:            return a & b;
            OP_OR:             return a | b;
            OP_SHL:            return a << im[`CPU_SHAMT_W-1:0];
            OP_SHR:            return a >> im[`CPU_SHAMT_W-1:0];
            OP_LOAD, OP_STORE: return a;                  // Address
            OP_LDM:            return im;
            default:           return '0;
        endcase
    endfunction

    function automatic flags_t model_flags(opcode_t op, data_t a, data_t b, data_t im,
                                           flags_t old);
        flags_t f;
        data_t  r;
        f = old;
        r = model_result(op, a, b, im);
        case (op)
            OP_ADD, OP_SUB, OP_INC, OP_DEC, OP_NOT, OP_AND, OP_OR, OP_SHL, OP_SHR: begin
                f[`CPU_FLAG_Z] = (r == '0);
                f[`CPU_FLAG_N] = r[`CPU_DATA_W-1];
            end
            default: ;
        endcase
        case (op)
            OP_ADD:  f[`CPU_FLAG_C] = (r < a);            // Wrapped sum means carry out
            OP_SUB:  f[`CPU_FLAG_C] = (a < b);            // Borrow
            OP_INC:  f[`CPU_FLAG_C] = (a == '1);
            OP_DEC:  f[`CPU_FLAG_C] = (a == '0);
            OP_SETC: f[`CPU_FLAG_C] = 1'b1;
            OP_CLRC: f[`CPU_FLAG_C] = 1'b0;
            default: ;
        endcase
        return f;
    endfunction

    // Order is mem_read, mem_write, push, pop, out_port, wb
    function automatic logic [5:0] model_strobes(opcode_t op);
        case (op)
            OP_LOAD, OP_LDM: return 6'b100001;
            OP_STORE:        return 6'b010000;
            OP_PUSH:         return 6'b001000;
            OP_POP:          return 6'b000100;
            OP_OUT:          return 6'b000010;
            OP_NOT, OP_INC, OP_DEC, OP_MOV, OP_ADD,
            OP_SUB, OP_AND, OP_OR, OP_SHL, OP_SHR: return 6'b000001;
            default:         return 6'b000000;
        endcase
    endfunction

    function automatic logic [5:0] strobes_of(mem_stage_t ms);
        return {ms.mem_read, ms.mem_write, ms.push, ms.pop, ms.out_port, ms.wb};
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s: %s expected 0x%0h actual 0x%0h",
                     cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_mark = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("%-22s done, %0d errors", cur_test, errors - err_mark);
    endtask

    // Starts and ends 2 ns after a rising edge, three edges apart
    task automatic exec_and_check(input opcode_t op, input data_t a, input data_t b,
                                  input data_t im, input data_t rdata, input bit squashed);
        opcode_t    eff;
        data_t      exp_res;
        flags_t     exp_flags;
        logic [5:0] exp_strb;
        eff       = squashed ? OP_NOP : op;                 // A squashed slot acts as NOP
        exp_res   = model_result(eff, a, b, im);
        exp_flags = model_flags(eff, a, b, im, model_flags_q);
        exp_strb  = model_strobes(eff);
        opcode    = op;
        operand_a = a;
        operand_b = b;
        imm       = im;
        @(posedge clk);
        #2;
        check_value("older slot strobes", 6'b0, strobes_of(mem_stage));
        opcode    = OP_NOP;
        @(posedge clk);
        #2;
        check_value("mem_stage strobes", exp_strb, strobes_of(mem_stage));
        if (exp_strb[5] || exp_strb[4] || exp_strb[0]) begin
            check_value("mem_stage result", exp_res, mem_stage.result);
        end
        if (exp_strb[4]) begin
            check_value("store_data", b, mem_stage.store_data);
        end
        check_value("flags", exp_flags, flags);
        model_flags_q = exp_flags;
        mem_rdata     = rdata;                              // Memory answers in its own stage
        @(posedge clk);
        #2;
        check_value("wb", exp_strb[0], wb_stage.wb);
        if (exp_strb[0]) begin
            check_value("wb_data", (eff == OP_LOAD) ? rdata : exp_res, wb_stage.wb_data);
        end
    endtask

    task automatic jump_then(input opcode_t jop, input opcode_t fop);
        logic  taken_exp;
        data_t a;
        data_t b;
        a = data_t'($urandom);
        b = data_t'($urandom);
        case (jop)
            OP_JZ:   taken_exp = model_flags_q[`CPU_FLAG_Z];
            OP_JN:   taken_exp = model_flags_q[`CPU_FLAG_N];
            OP_JC:   taken_exp = model_flags_q[`CPU_FLAG_C];
            default: taken_exp = 1'b0;
        endcase
        opcode    = jop;
        operand_a = data_t'($urandom);
        @(posedge clk);
        #2;
        check_value("jump_taken", taken_exp, jump_taken);
        exec_and_check(fop, a, b, '0, '0, taken_exp);
    endtask

    task automatic test_reset_state();
        start_test("reset_state");
        check_value("mem_stage strobes", 6'b0, strobes_of(mem_stage));
        check_value("wb", 1'b0, wb_stage.wb);
        check_value("flags", 3'b0, flags);
        check_value("jump_taken", 1'b0, jump_taken);
        end_test();
    endtask

    task automatic test_alu_writeback();
        opcode_t op;
        data_t   a;
        data_t   b;
        start_test("alu_writeback");
        for (int i = 0; i < N_ALU; i++) begin
            op = alu_ops[$urandom_range(0, 9)];
            a  = data_t'($urandom);
            b  = data_t'($urandom);
            if ($urandom_range(0, 7) == 0) begin
                b = a;                                    // Reach the zero flag now and then
            end
            exec_and_check(op, a, b, data_t'($urandom), '0, 1'b0);
        end
        end_test();
    endtask

    task automatic test_no_writeback();
        opcode_t ops [7] = '{OP_CLRC, OP_SETC, OP_IN, OP_OUT, OP_PUSH, OP_POP, OP_CLRC};
        start_test("carry_and_strobes");
        foreach (ops[i]) begin
            exec_and_check(ops[i], data_t'($urandom), data_t'($urandom), '0, '0, 1'b0);
        end
        end_test();
    endtask

    task automatic test_memory();
        start_test("memory");
        exec_and_check(OP_LOAD, data_t'($urandom), '0, '0, data_t'($urandom), 1'b0);
        exec_and_check(OP_STORE, data_t'($urandom), data_t'($urandom), '0, '0, 1'b0);
        exec_and_check(OP_LDM, '0, '0, data_t'($urandom), data_t'($urandom), 1'b0);
        exec_and_check(OP_LOAD, data_t'($urandom), '0, '0, data_t'($urandom), 1'b0);
        end_test();
    endtask

    task automatic test_jumps();
        data_t x;
        start_test("jumps");
        x = data_t'($urandom);
        exec_and_check(OP_SUB, x, x, '0, '0, 1'b0);      // Z set, N and C clear
        jump_then(OP_JZ, OP_STORE);
        jump_then(OP_JC, OP_STORE);
        jump_then(OP_JN, OP_ADD);
        exec_and_check(OP_SETC, '0, '0, '0, '0, 1'b0);
        jump_then(OP_JC, OP_ADD);
        exec_and_check(OP_NOT, '0, '0, '0, '0, 1'b0);    // N set, Z clear
        jump_then(OP_JN, OP_STORE);
        jump_then(OP_JZ, OP_ADD);
        end_test();
    endtask

    initial begin
        void'($urandom(32'hd50e));
        rst_n         = 1'b0;
        opcode        = OP_NOP;
        operand_a     = '0;
        operand_b     = '0;
        imm           = '0;
        mem_rdata     = '0;
        model_flags_q = '0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset_state();
        test_alu_writeback();
        test_no_writeback();
        test_memory();
        test_jumps();
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
